/* hdl/ntm_arith_pkg.sv */
////////////////////////////////////////
// Shared types for the tensor product engine
// Data, index and bus address widths
// Configuration struct and FSM encodings
// Wishbone register map
////////////////////////////////////////

`default_nettype none

package ntm_arith_pkg;

  // Default element width, top level must agree
  localparam int NTM_DATA_SIZE = 32;

  typedef logic [NTM_DATA_SIZE-1:0] data_t;
  typedef logic [15:0]              index_t;
  typedef logic [2:0]               wb_addr_t;

  // Run configuration, written by the host
  typedef struct packed {
    data_t  modulo;
    index_t size_i;
    index_t size_j;
    index_t length;
  } ntm_cfg_t;

  // FSM encodings
  typedef enum logic [0:0] {MUL_IDLE, MUL_RUN} mult_state_t;
  typedef enum logic [1:0] {VEC_IDLE, VEC_WAIT_ELEMENT, VEC_MULTIPLY, VEC_EMIT} vector_state_t;
  typedef enum logic [1:0] {MAT_IDLE, MAT_START_ROW, MAT_STREAM, MAT_DONE} matrix_state_t;

  // Word addresses of the register block
  localparam wb_addr_t REG_CTRL   = 3'd0;
  localparam wb_addr_t REG_MODULO = 3'd1;
  localparam wb_addr_t REG_SIZE_I = 3'd2;
  localparam wb_addr_t REG_SIZE_J = 3'd3;
  localparam wb_addr_t REG_LENGTH = 3'd4;
  localparam wb_addr_t REG_DATA   = 3'd5;
  localparam wb_addr_t REG_STATUS = 3'd6;
  localparam wb_addr_t REG_RESULT = 3'd7;

endpackage

`default_nettype wire

/* hdl/ntm_modular_multiplier.sv */
////////////////////////////////////////
// Bit-serial modular multiplier
// MSB-first shift-add, one bit per clock
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_modular_multiplier
  import ntm_arith_pkg::*;
#(
  parameter int DATA_SIZE = NTM_DATA_SIZE
) (
  input  wire   CLK,
  input  wire   RST,
  input  logic  start,
  input  data_t a,
  input  data_t b,
  input  data_t m,
  output logic  ready,
  output data_t product
);

  localparam int CNT_W = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;

  // Two guard bits for 2*acc + a before reduction
  typedef logic [DATA_SIZE+1:0] wide_t;

  mult_state_t      state;
  logic [CNT_W-1:0] bit_cnt;
  data_t            a_q;
  data_t            b_q;
  data_t            m_q;
  data_t            acc;
  wide_t            dbl;
  wide_t            sum;
  wide_t            red1;
  wide_t            red2;

  // One step: double, add a on a set bit, fold back below m
  always_comb begin
    dbl  = wide_t'(acc) << 1;
    sum  = b_q[DATA_SIZE-1] ? dbl + wide_t'(a_q) : dbl;
    // Sum is below 3m, so two subtractions suffice
    red1 = (sum >= wide_t'(m_q)) ? sum - wide_t'(m_q) : sum;
    red2 = (red1 >= wide_t'(m_q)) ? red1 - wide_t'(m_q) : red1;
  end

  // Step counter and ready pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= MUL_IDLE;
      bit_cnt <= '0;
      ready   <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        MUL_IDLE: begin
          if (start) begin
            state   <= MUL_RUN;
            bit_cnt <= CNT_W'(DATA_SIZE - 1);
          end
        end
        MUL_RUN: begin
          if (bit_cnt == '0) begin
            // Last bit done, product valid next cycle
            state <= MUL_IDLE;
            ready <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // Operand capture and partial result
  always_ff @(posedge CLK) begin
    if (state == MUL_IDLE && start) begin
      a_q <= a;
      b_q <= b;
      m_q <= m;
      acc <= '0;
    end else if (state == MUL_RUN) begin
      acc <= data_t'(red2);
      // Next bit of b into the MSB
      b_q <= b_q << 1;
      if (bit_cnt == '0) begin
        product <= data_t'(red2);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ntm_vector_multiplication_function.sv */
////////////////////////////////////////
// Row engine
// Columns of length-element modular products
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_vector_multiplication_function
  import ntm_arith_pkg::*;
#(
  parameter int DATA_SIZE = NTM_DATA_SIZE
) (
  input  wire      CLK,
  input  wire      RST,
  input  logic     start,
  input  ntm_cfg_t cfg,
  input  logic     elem_valid,
  input  data_t    elem_data,
  output logic     elem_ready,
  output logic     res_valid,
  input  logic     res_ready,
  output data_t    res_data,
  output logic     res_row_last
);

  vector_state_t state;
  index_t        col;
  index_t        scal;
  index_t        last_col;
  index_t        last_scal;
  data_t         acc;
  logic          mul_start;
  logic          mul_ready;
  data_t         mul_product;

  assign last_col  = cfg.size_j - 16'd1;
  assign last_scal = cfg.length - 16'd1;

  // Handshakes straight from the state
  assign elem_ready = (state == VEC_WAIT_ELEMENT);
  assign res_valid  = (state == VEC_EMIT);
  // Multiplier kicks off in the accept cycle
  assign mul_start  = elem_valid && elem_ready;

  ////////////////////////////////////////
  // Loop control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= VEC_IDLE;
      col   <= '0;
      scal  <= '0;
    end else begin
      case (state)
        VEC_IDLE: begin
          if (start) begin
            col   <= '0;
            scal  <= '0;
            state <= VEC_WAIT_ELEMENT;
          end
        end
        VEC_WAIT_ELEMENT: begin
          if (mul_start) state <= VEC_MULTIPLY;
        end
        VEC_MULTIPLY: begin
          if (mul_ready) begin
            if (scal == last_scal) begin
              scal  <= '0;
              state <= VEC_EMIT;
            end else begin
              scal  <= scal + 16'd1;
              state <= VEC_WAIT_ELEMENT;
            end
          end
        end
        VEC_EMIT: begin
          if (res_ready) begin
            // Row finished after the final column
            if (col == last_col) begin
              state <= VEC_IDLE;
            end else begin
              col   <= col + 16'd1;
              state <= VEC_WAIT_ELEMENT;
            end
          end
        end
        default: state <= VEC_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Accumulator and result
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == VEC_IDLE && start) begin
      acc <= data_t'(1);
    end else if (state == VEC_MULTIPLY && mul_ready) begin
      acc          <= mul_product;
      res_data     <= mul_product;
      res_row_last <= (col == last_col);
    end else if (state == VEC_EMIT && res_ready) begin
      // Fresh accumulator per column
      acc <= data_t'(1);
    end
  end

  ntm_modular_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) u_multiplier (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .a       (acc),
    .b       (elem_data),
    .m       (cfg.modulo),
    .ready   (mul_ready),
    .product (mul_product)
  );

endmodule

`default_nettype wire

/* hdl/ntm_matrix_multiplication_function.sv */
////////////////////////////////////////
// Matrix controller
// Row sequencing, element gating, result push
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_multiplication_function
  import ntm_arith_pkg::*;
#(
  parameter int DATA_SIZE = NTM_DATA_SIZE
) (
  input  wire      CLK,
  input  wire      RST,
  input  logic     start,
  input  ntm_cfg_t cfg,
  input  logic     elem_valid,
  input  data_t    elem_data,
  output logic     elem_ready,
  output logic     push,
  output data_t    push_data,
  input  logic     fifo_full,
  output logic     busy,
  output logic     done
);

  matrix_state_t state;
  ntm_cfg_t      cfg_q;
  index_t        row;
  index_t        last_row;
  logic          idle;
  logic          row_start;
  logic          vec_elem_valid;
  logic          vec_elem_ready;
  logic          res_valid;
  logic          res_ready;
  data_t         res_data;
  logic          res_row_last;

  assign last_row = cfg_q.size_i - 16'd1;

  // Ready for a new run, before or after a matrix
  assign idle = (state == MAT_IDLE) || (state == MAT_DONE);

  ////////////////////////////////////////
  // Row engine handshakes
  ////////////////////////////////////////

  assign row_start = (state == MAT_START_ROW);

  // Elements pass only while a row streams
  assign vec_elem_valid = elem_valid && (state == MAT_STREAM);
  assign elem_ready     = vec_elem_ready && (state == MAT_STREAM);

  // Full FIFO holds the result in the row engine
  assign res_ready = (state == MAT_STREAM) && !fifo_full;
  assign push      = res_valid && res_ready;
  assign push_data = res_data;

  // Status
  assign busy = (state == MAT_START_ROW) || (state == MAT_STREAM);
  assign done = (state == MAT_DONE);

  ////////////////////////////////////////
  // Row sequencing
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= MAT_IDLE;
      row   <= '0;
    end else begin
      case (state)
        MAT_IDLE, MAT_DONE: begin
          if (start) begin
            row   <= '0;
            state <= MAT_START_ROW;
          end
        end
        MAT_START_ROW: begin
          state <= MAT_STREAM;
        end
        MAT_STREAM: begin
          // Row ends with the push of its last column
          if (push && res_row_last) begin
            if (row == last_row) begin
              state <= MAT_DONE;
            end else begin
              row   <= row + 16'd1;
              state <= MAT_START_ROW;
            end
          end
        end
        default: state <= MAT_IDLE;
      endcase
    end
  end

  // Configuration frozen for the whole run
  always_ff @(posedge CLK) begin
    if (idle && start) begin
      cfg_q <= cfg;
    end
  end

  ntm_vector_multiplication_function #(
    .DATA_SIZE(DATA_SIZE)
  ) u_vector (
    .CLK          (CLK),
    .RST          (RST),
    .start        (row_start),
    .cfg          (cfg_q),
    .elem_valid   (vec_elem_valid),
    .elem_data    (elem_data),
    .elem_ready   (vec_elem_ready),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res_data     (res_data),
    .res_row_last (res_row_last)
  );

endmodule

`default_nettype wire

/* hdl/ntm_result_fifo.sv */
////////////////////////////////////////
// Result FIFO
// Circular buffer with occupancy count
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_result_fifo
  import ntm_arith_pkg::*;
#(
  parameter int DATA_SIZE  = NTM_DATA_SIZE,
  parameter int FIFO_DEPTH = 16
) (
  input  wire   CLK,
  input  wire   RST,
  input  logic  push,
  input  data_t push_data,
  input  logic  pop,
  output data_t head,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DATA_SIZE-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  logic                 do_push;
  logic                 do_pop;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(FIFO_DEPTH));
  // Overflow and underflow are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  // Pointers wrap at the depth, any size
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

/* hdl/ntm_wb_slave.sv */
////////////////////////////////////////
// Wishbone classic register block
// Config, start, element and result ports
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_wb_slave
  import ntm_arith_pkg::*;
#(
  parameter int DATA_SIZE = NTM_DATA_SIZE
) (
  input  wire      CLK,
  input  wire      RST,
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_addr_t wb_adr,
  input  data_t    wb_dat_w,
  output data_t    wb_dat_r,
  output logic     wb_ack,
  output ntm_cfg_t cfg,
  output logic     start,
  output logic     elem_valid,
  output data_t    elem_data,
  input  logic     elem_ready,
  input  logic     busy,
  input  logic     done,
  input  data_t    head,
  input  logic     empty,
  output logic     pop
);

  logic  req;
  data_t status;

  // Ack cycle masked so one access acts once
  assign req = wb_cyc && wb_stb && !wb_ack;

  // Busy, result available, done
  assign status = {{(DATA_SIZE-3){1'b0}}, done, !empty, busy};

  // Element offered while the DATA write is pending
  assign elem_valid = req && wb_we && (wb_adr == REG_DATA);
  assign elem_data  = wb_dat_w;

  ////////////////////////////////////////
  // Ack, config and strobes
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      pop    <= 1'b0;
      cfg    <= '0;
    end else begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      pop    <= 1'b0;
      if (req && wb_we) begin
        case (wb_adr)
          REG_CTRL: begin
            start  <= wb_dat_w[0];
            wb_ack <= 1'b1;
          end
          REG_MODULO: begin
            cfg.modulo <= wb_dat_w;
            wb_ack     <= 1'b1;
          end
          REG_SIZE_I: begin
            cfg.size_i <= index_t'(wb_dat_w);
            wb_ack     <= 1'b1;
          end
          REG_SIZE_J: begin
            cfg.size_j <= index_t'(wb_dat_w);
            wb_ack     <= 1'b1;
          end
          REG_LENGTH: begin
            cfg.length <= index_t'(wb_dat_w);
            wb_ack     <= 1'b1;
          end
          // Back-pressure until the controller takes it
          REG_DATA: wb_ack <= elem_ready;
          default:  wb_ack <= 1'b1;
        endcase
      end else if (req) begin
        if (wb_adr == REG_RESULT) begin
          // Wait for a result, pop together with ack
          if (!empty) begin
            wb_ack <= 1'b1;
            pop    <= 1'b1;
          end
        end else begin
          wb_ack <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (req && !wb_we) begin
      case (wb_adr)
        REG_MODULO: wb_dat_r <= cfg.modulo;
        REG_SIZE_I: wb_dat_r <= data_t'(cfg.size_i);
        REG_SIZE_J: wb_dat_r <= data_t'(cfg.size_j);
        REG_LENGTH: wb_dat_r <= data_t'(cfg.length);
        REG_STATUS: wb_dat_r <= status;
        REG_RESULT: wb_dat_r <= head;
        // CTRL and DATA read as zero
        default:    wb_dat_r <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/ntm_matrix_top.sv */
////////////////////////////////////////
// Tensor product engine top level
// Bus slave, controller and result FIFO
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_top
  import ntm_arith_pkg::*;
#(
  parameter int DATA_SIZE  = NTM_DATA_SIZE,
  parameter int FIFO_DEPTH = 16
) (
  input  wire      CLK,
  input  wire      RST,
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_addr_t wb_adr,
  input  data_t    wb_dat_w,
  output data_t    wb_dat_r,
  output logic     wb_ack
);

  // Slave to controller
  ntm_cfg_t cfg;
  logic     start;
  logic     elem_valid;
  logic     elem_ready;
  data_t    elem_data;
  logic     busy;
  logic     done;

  // Controller, FIFO and slave
  logic     push;
  data_t    push_data;
  logic     full;
  logic     pop;
  data_t    head;
  logic     empty;

  ntm_wb_slave #(
    .DATA_SIZE(DATA_SIZE)
  ) u_slave (
    .CLK        (CLK),
    .RST        (RST),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .cfg        (cfg),
    .start      (start),
    .elem_valid (elem_valid),
    .elem_data  (elem_data),
    .elem_ready (elem_ready),
    .busy       (busy),
    .done       (done),
    .head       (head),
    .empty      (empty),
    .pop        (pop)
  );

  ntm_matrix_multiplication_function #(
    .DATA_SIZE(DATA_SIZE)
  ) u_matrix (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .cfg        (cfg),
    .elem_valid (elem_valid),
    .elem_data  (elem_data),
    .elem_ready (elem_ready),
    .push       (push),
    .push_data  (push_data),
    .fifo_full  (full),
    .busy       (busy),
    .done       (done)
  );

  ntm_result_fifo #(
    .DATA_SIZE  (DATA_SIZE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

endmodule

`default_nettype wire

/* testbench/tb_ntm_bus_tasks.svh */
////////////////////////////////////////
// Testbench helpers for the tensor engine
// Wishbone write and read with timeouts
// Value check, LCG and reference model
////////////////////////////////////////

`ifndef TB_NTM_BUS_TASKS_SVH
`define TB_NTM_BUS_TASKS_SVH

  ////////////////////////////////////////
  // Failure bookkeeping
  ////////////////////////////////////////

  // Counts as an error and stops further bus traffic
  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("Timeout: %s", what);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Wishbone classic master
  ////////////////////////////////////////

  task automatic wb_write(input wb_addr_t adr, input logic [31:0] dat);
    int waited;
    if (aborted) return;
    @(posedge CLK);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    waited = 0;
    // DATA writes may stall on back-pressure
    do begin
      @(posedge CLK);
      waited++;
    end while (!wb_ack && waited < BUS_TIMEOUT);
    if (!wb_ack) begin
      report_timeout($sformatf("no ack for bus write to address %0d within %0d cycles",
                               adr, BUS_TIMEOUT));
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t adr, output logic [31:0] dat);
    int waited;
    dat = '0;
    if (aborted) return;
    @(posedge CLK);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    waited = 0;
    // RESULT reads wait for a non-empty FIFO
    do begin
      @(posedge CLK);
      waited++;
    end while (!wb_ack && waited < BUS_TIMEOUT);
    if (wb_ack) begin
      dat = wb_dat_r;
    end else begin
      report_timeout($sformatf("no ack for bus read from address %0d within %0d cycles",
                               adr, BUS_TIMEOUT));
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Product of elems[first +: count] mod m, from 1
  function automatic logic [31:0] ref_product(input int first, input int count,
                                              input logic [31:0] m);
    logic [63:0] acc;
    acc = 64'd1;
    for (int k = 0; k < count; k++) begin
      acc = (acc * {32'd0, elems[first + k]}) % {32'd0, m};
    end
    return acc[31:0];
  endfunction

`endif

/* testbench/tb_ntm_matrix_top.sv */
////////////////////////////////////////
// Testbench for the tensor product engine
// Clock, reset, test sequence, summary
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ntm_matrix_top
  import ntm_arith_pkg::*;
();

  localparam int DATA_SIZE   = 32;
  localparam int FIFO_DEPTH  = 16;
  localparam int BUS_TIMEOUT = 2000;
  localparam int DONE_POLLS  = 500;

  logic        CLK;
  logic        RST;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_addr_t    wb_adr;
  data_t       wb_dat_w;
  data_t       wb_dat_r;
  logic        wb_ack;

  // Run state shared with the helpers
  logic [31:0] lcg_state;
  logic [31:0] elems [0:63];
  logic [31:0] results [0:15];
  logic [31:0] cur_m;
  int          cur_len;
  int          errors;
  int          checks;
  int          mark;
  int          tests_run;
  int          tests_failed;
  bit          aborted;

  `include "tb_ntm_bus_tasks.svh"

  ntm_matrix_top #(
    .DATA_SIZE  (DATA_SIZE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Run helpers
  ////////////////////////////////////////

  task automatic load_config(input logic [31:0] m, input int si, input int sj, input int len);
    wb_write(REG_MODULO, m);
    wb_write(REG_SIZE_I, si);
    wb_write(REG_SIZE_J, sj);
    wb_write(REG_LENGTH, len);
    cur_m   = m;
    cur_len = len;
  endtask

  // Elements kept below the modulus
  task automatic fill_elements(input int count);
    for (int k = 0; k < count; k++) elems[k] = lcg_next() % cur_m;
  endtask

  // Start, stream row-major, collect results in order
  task automatic run_matrix(input int n_elem, input int n_res);
    wb_write(REG_CTRL, 32'd1);
    for (int k = 0; k < n_elem; k++) wb_write(REG_DATA, elems[k]);
    for (int k = 0; k < n_res; k++) wb_read(REG_RESULT, results[k]);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[2] && !aborted && polls < DONE_POLLS) begin
      wb_read(REG_STATUS, status);
      polls++;
    end
    if (!status[2] && !aborted) begin
      report_timeout($sformatf("STATUS did not show done within %0d polls", DONE_POLLS));
    end
  endtask

  task automatic compare_model(input string name, input int n_res);
    for (int k = 0; k < n_res; k++) begin
      check_value($sformatf("%s result %0d", name, k), results[k],
                  ref_product(k * cur_len, cur_len, cur_m));
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == mark) begin
      $display("Test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("Test %-14s FAILED with %0d errors", name, errors - mark);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] got;
    RST       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    lcg_state = 32'h81524d50;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted   = 1'b0;
    repeat (8) @(posedge CLK);
    RST <= 1'b0;

    // Register read-back and idle status
    mark = errors;
    wb_read(REG_STATUS, got);
    check_value("status after reset", got, 32'd0);
    load_config(32'h1234_5679, 32'h00a5, 32'h5a01, 32'h0102);
    wb_read(REG_MODULO, got);
    check_value("modulo", got, 32'h1234_5679);
    wb_read(REG_SIZE_I, got);
    check_value("size_i", got, 32'h00a5);
    wb_read(REG_SIZE_J, got);
    check_value("size_j", got, 32'h5a01);
    wb_read(REG_LENGTH, got);
    check_value("length", got, 32'h0102);
    end_test("registers");

    // 2x3, length 4, mod 97
    mark = errors;
    load_config(32'd97, 2, 3, 4);
    fill_elements(24);
    run_matrix(24, 6);
    compare_model("single matrix", 6);
    end_test("single matrix");

    // Length one gives the element back
    mark = errors;
    load_config(32'h7fff_ffed, 2, 2, 1);
    fill_elements(4);
    run_matrix(4, 4);
    for (int k = 0; k < 4; k++) begin
      check_value($sformatf("length one result %0d", k), results[k], elems[k]);
    end
    end_test("length one");

    // All 12 results parked in the FIFO until done
    mark = errors;
    load_config(32'd65521, 3, 4, 2);
    fill_elements(24);
    wb_write(REG_CTRL, 32'd1);
    for (int k = 0; k < 24; k++) wb_write(REG_DATA, elems[k]);
    wait_done();
    wb_read(REG_STATUS, got);
    check_value("status before reads", got & 32'd7, 32'd6);
    for (int k = 0; k < 12; k++) wb_read(REG_RESULT, results[k]);
    compare_model("back-pressure", 12);
    end_test("back-pressure");

    // Zeros in columns 0 and 3, then a fresh second run
    mark = errors;
    load_config(32'd101, 2, 2, 3);
    fill_elements(12);
    elems[1]  = 32'd0;
    elems[11] = 32'd0;
    run_matrix(12, 4);
    check_value("zero column 0", results[0], 32'd0);
    check_value("zero column 3", results[3], 32'd0);
    check_value("column 1", results[1], ref_product(3, 3, cur_m));
    check_value("column 2", results[2], ref_product(6, 3, cur_m));
    fill_elements(12);
    run_matrix(12, 4);
    compare_model("second run", 4);
    wait_done();
    wb_read(REG_STATUS, got);
    // Done only, FIFO drained
    check_value("status after second run", got & 32'd7, 32'd4);
    end_test("zero element");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ntm_matrix_product.f */
+incdir+testbench
hdl/ntm_arith_pkg.sv
hdl/ntm_modular_multiplier.sv
hdl/ntm_vector_multiplication_function.sv
hdl/ntm_matrix_multiplication_function.sv
hdl/ntm_result_fifo.sv
hdl/ntm_wb_slave.sv
hdl/ntm_matrix_top.sv
testbench/tb_ntm_matrix_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_ntm_matrix_top
FILELIST  := ntm_matrix_product.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) testbench/tb_ntm_bus_tasks.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
